// File: verilog/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

        localparam int xlen         = 32;
        localparam int reg_addr_w   = 5;
        localparam int num_regs     = 32;
        localparam int num_rd_ports = 2;  // rj and rk/rd

        // immediate field widths
        localparam int i12_w = 12;
        localparam int i16_w = 16;
        localparam int i20_w = 20;
        localparam int i26_w = 26;

        typedef logic [reg_addr_w-1:0] reg_addr_t;
        typedef logic [xlen-1:0]       word_t;

        typedef enum logic [4:0] {
                inst_add_w,
                inst_sub_w,
                inst_slt,
                inst_sltu,
                inst_and,
                inst_or,
                inst_nor,
                inst_xor,
                inst_addi_w,
                inst_lu12i_w,
                inst_ld_w,
                inst_st_w,
                inst_beq,
                inst_bne,
                inst_b,
                inst_bl,
                inst_jirl,
                inst_invalid
        } inst_op_e;

        typedef enum logic [3:0] {
                alu_add,
                alu_sub,
                alu_slt,
                alu_sltu,
                alu_and,
                alu_or,
                alu_nor,
                alu_xor,
                alu_lui
        } alu_op_e;

endpackage

`default_nettype wire

// File: verilog/id_bus_pkg.sv
`default_nettype none

package id_bus_pkg;

        import la_isa_pkg::*;

        typedef struct packed {
                word_t pc;
                word_t inst;
        } fs_to_ds_t;

        typedef struct packed {
                logic  taken;
                word_t target;
        } br_t;

        typedef struct packed {
                logic      we;
                reg_addr_t waddr;
                word_t     wdata;
        } wb_rf_t;

        // bypass source, is_load only from execute
        typedef struct packed {
                logic      vwe;
                logic      is_load;
                reg_addr_t dest;
                word_t     wdata;
        } fw_t;

        typedef struct packed {
                inst_op_e                     op;
                alu_op_e                      alu_op;
                logic                         src1_is_pc;
                logic                         src2_is_imm;
                reg_addr_t [num_rd_ports-1:0] raddr;  // [0] rj, [1] rk or rd
                logic [num_rd_ports-1:0]      used;
                logic                         res_from_mem;
                logic                         gr_we;
                logic                         mem_we;
                reg_addr_t                    dest;
                word_t                        imm;
                word_t                        br_offs;
        } dec_t;

        typedef struct packed {
                word_t     pc;
                alu_op_e   alu_op;
                logic      res_from_mem;
                logic      gr_we;
                logic      mem_we;
                reg_addr_t dest;
                word_t     alu_src1;
                word_t     alu_src2;
                word_t     rkd_value;  // store data
        } ds_to_es_t;

endpackage

`default_nettype wire

// File: verilog/decode_latch.sv
`timescale 1ns/1ns
`default_nettype none

module decode_latch (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   fs_to_ds_valid,
        input  id_bus_pkg::fs_to_ds_t  fs_to_ds,
        input  logic                   es_allowin,
        input  logic [1:0]             hazard,
        output logic                   ds_allowin,
        output logic                   ds_valid,
        output la_isa_pkg::word_t      pc,
        output la_isa_pkg::word_t      inst,
        output logic                   ds_to_es_valid
);
        import id_bus_pkg::*;

        fs_to_ds_t ds_reg;
        logic      ready_go;

        assign ready_go       = ~|hazard;  // only a load-use blocks
        assign ds_allowin     = ~ds_valid | (ready_go & es_allowin);
        assign ds_to_es_valid = ds_valid & ready_go;

        always_ff @(posedge clk) begin
                if (reset) begin
                        ds_valid <= 1'b0;
                end else if (ds_allowin) begin
                        ds_valid <= fs_to_ds_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (ds_allowin && fs_to_ds_valid) begin
                        ds_reg <= fs_to_ds;
                end
        end

        assign pc   = ds_reg.pc;
        assign inst = ds_reg.inst;

        // a stalled or back-pressured item must not move under execute
        a_hold_stable: assert property (@(posedge clk) disable iff (reset)
                ds_valid && !ds_allowin |=> $stable({pc, inst}))
                else $error("decode_latch: pc/inst changed while held");

endmodule

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decode (
        input  la_isa_pkg::word_t  inst,
        output id_bus_pkg::dec_t   dec
);
        import la_isa_pkg::*;

        inst_op_e         op;
        reg_addr_t        rd;
        reg_addr_t        rj;
        reg_addr_t        rk;
        logic [i12_w-1:0] i12;
        logic [i16_w-1:0] i16;
        logic [i20_w-1:0] i20;
        logic [i26_w-1:0] i26;
        logic             src_reg_is_rd;

        assign rd  = inst[4:0];
        assign rj  = inst[9:5];
        assign rk  = inst[14:10];
        assign i12 = inst[21:10];
        assign i16 = inst[25:10];
        assign i20 = inst[24:5];
        assign i26 = {inst[9:0], inst[25:10]};  // offs[25:16] sits low

        always_comb begin
                op = inst_invalid;
                case (inst[31:26])
                        6'h00: begin
                                if (inst[25:20] == 6'b0000_01) begin
                                        case (inst[19:15])
                                                5'h00: op = inst_add_w;
                                                5'h02: op = inst_sub_w;
                                                5'h04: op = inst_slt;
                                                5'h05: op = inst_sltu;
                                                5'h08: op = inst_nor;
                                                5'h09: op = inst_and;
                                                5'h0a: op = inst_or;
                                                5'h0b: op = inst_xor;
                                                default: op = inst_invalid;
                                        endcase
                                end else if (inst[25:22] == 4'ha) begin
                                        op = inst_addi_w;
                                end
                        end
                        6'h05: if (!inst[25]) op = inst_lu12i_w;
                        6'h0a: begin
                                if (inst[25:22] == 4'h2) op = inst_ld_w;
                                else if (inst[25:22] == 4'h6) op = inst_st_w;
                        end
                        6'h13: op = inst_jirl;
                        6'h14: op = inst_b;
                        6'h15: op = inst_bl;
                        6'h16: op = inst_beq;
                        6'h17: op = inst_bne;
                        default: op = inst_invalid;
                endcase
        end

        assign src_reg_is_rd = op inside {inst_st_w, inst_beq, inst_bne};

        always_comb begin
                dec.op = op;
                case (op)
                        inst_sub_w:   dec.alu_op = alu_sub;
                        inst_slt:     dec.alu_op = alu_slt;
                        inst_sltu:    dec.alu_op = alu_sltu;
                        inst_and:     dec.alu_op = alu_and;
                        inst_or:      dec.alu_op = alu_or;
                        inst_nor:     dec.alu_op = alu_nor;
                        inst_xor:     dec.alu_op = alu_xor;
                        inst_lu12i_w: dec.alu_op = alu_lui;
                        default:      dec.alu_op = alu_add;  // also addresses and link
                endcase
                dec.src1_is_pc  = op inside {inst_jirl, inst_bl};
                dec.src2_is_imm = op inside {inst_addi_w, inst_lu12i_w, inst_ld_w,
                                             inst_st_w, inst_jirl, inst_bl};
                dec.raddr[0]    = rj;
                dec.raddr[1]    = src_reg_is_rd ? rd : rk;
                dec.used[0]     = !(op inside {inst_lu12i_w, inst_b, inst_bl, inst_invalid});
                dec.used[1]     = op inside {inst_add_w, inst_sub_w, inst_slt, inst_sltu,
                                             inst_and, inst_or, inst_nor, inst_xor,
                                             inst_st_w, inst_beq, inst_bne};
                dec.res_from_mem = op == inst_ld_w;
                dec.mem_we      = op == inst_st_w;
                dec.gr_we       = !(op inside {inst_st_w, inst_beq, inst_bne, inst_b,
                                               inst_invalid});
                dec.dest        = (op == inst_bl) ? reg_addr_t'(1) : rd;  // link reg

                if (op inside {inst_jirl, inst_bl}) begin
                        dec.imm = word_t'(4);
                end else if (op == inst_lu12i_w) begin
                        dec.imm = {i20, {(xlen-i20_w){1'b0}}};
                end else begin
                        dec.imm = {{(xlen-i12_w){i12[i12_w-1]}}, i12};
                end

                if (op inside {inst_b, inst_bl}) begin
                        dec.br_offs = {{(xlen-i26_w-2){i26[i26_w-1]}}, i26, 2'b00};
                end else begin
                        dec.br_offs = {{(xlen-i16_w-2){i16[i16_w-1]}}, i16, 2'b00};
                end
        end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
        input  logic                            clk,
        input  la_isa_pkg::reg_addr_t [1:0]     raddr,
        input  logic                            we,
        input  la_isa_pkg::reg_addr_t           waddr,
        input  la_isa_pkg::word_t               wdata,
        output la_isa_pkg::word_t [1:0]         rdata
);
        import la_isa_pkg::*;

        word_t regs [num_regs];

        always_ff @(posedge clk) begin
                if (we && waddr != '0) begin  // r0 stays unwritten
                        regs[waddr] <= wdata;
                end
        end

        // same-cycle write shows up through the ws bypass, not here
        always_comb begin
                for (int p = 0; p < num_rd_ports; p++) begin
                        rdata[p] = regs[raddr[p]];
                end
        end

endmodule

`default_nettype wire

// File: verilog/operand_fwd.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fwd (
        input  la_isa_pkg::reg_addr_t  raddr,
        input  logic                   used,
        input  la_isa_pkg::word_t      rf_rdata,
        input  id_bus_pkg::fw_t        es_fw,
        input  id_bus_pkg::fw_t        ms_fw,
        input  id_bus_pkg::fw_t        ws_fw,
        output la_isa_pkg::word_t      value,
        output logic                   hazard
);
        logic es_hit;
        logic ms_hit;
        logic ws_hit;

        // a load in execute has no data yet
        assign es_hit = es_fw.vwe & ~es_fw.is_load & (es_fw.dest == raddr);
        assign ms_hit = ms_fw.vwe & (ms_fw.dest == raddr);
        assign ws_hit = ws_fw.vwe & (ws_fw.dest == raddr);

        always_comb begin
                if (raddr == '0) begin
                        value = '0;
                end else if (es_hit) begin
                        value = es_fw.wdata;
                end else if (ms_hit) begin
                        value = ms_fw.wdata;
                end else if (ws_hit) begin
                        value = ws_fw.wdata;
                end else begin
                        value = rf_rdata;
                end
        end

        assign hazard = used & es_fw.is_load & es_fw.vwe & (es_fw.dest != '0)
                        & (es_fw.dest == raddr);

        // r0 must read zero whatever any stage writes
        always_comb begin
                a_r0_zero: assert final (raddr != '0 || value == '0)
                        else $error("operand_fwd: r0 read as %h", value);
        end

endmodule

`default_nettype wire

// File: verilog/issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

module issue_unit (
        input  logic                   ds_valid,
        input  la_isa_pkg::word_t      pc,
        input  id_bus_pkg::dec_t       dec,
        input  la_isa_pkg::word_t      rj_value,
        input  la_isa_pkg::word_t      rkd_value,
        output id_bus_pkg::br_t        br,
        output id_bus_pkg::ds_to_es_t  ds_to_es
);
        import la_isa_pkg::*;

        logic  rel_eq;
        logic  cond_taken;
        word_t br_base;

        assign rel_eq = rj_value == rkd_value;

        always_comb begin
                case (dec.op)
                        inst_beq:                     cond_taken = rel_eq;
                        inst_bne:                     cond_taken = ~rel_eq;
                        inst_b, inst_bl, inst_jirl:   cond_taken = 1'b1;
                        default:                      cond_taken = 1'b0;
                endcase
        end

        assign br_base = (dec.op == inst_jirl) ? rj_value : pc;  // jirl is register relative

        always_comb begin
                br.taken  = ds_valid & cond_taken;
                br.target = br_base + dec.br_offs;
        end

        always_comb begin
                ds_to_es.pc           = pc;
                ds_to_es.alu_op       = dec.alu_op;
                ds_to_es.res_from_mem = dec.res_from_mem;
                ds_to_es.gr_we        = dec.gr_we;
                ds_to_es.mem_we       = dec.mem_we;
                ds_to_es.dest         = dec.dest;
                ds_to_es.alu_src1     = dec.src1_is_pc ? pc : rj_value;
                ds_to_es.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
                ds_to_es.rkd_value    = rkd_value;
        end

        // fetch must never redirect on an empty stage
        always_comb begin
                a_taken_valid: assert final (!br.taken || ds_valid)
                        else $error("issue_unit: branch taken with ds_valid low");
        end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   fs_to_ds_valid,
        input  id_bus_pkg::fs_to_ds_t  fs_to_ds,
        input  logic                   es_allowin,
        input  id_bus_pkg::wb_rf_t     wb_rf,
        input  id_bus_pkg::fw_t        es_fw,
        input  id_bus_pkg::fw_t        ms_fw,
        input  id_bus_pkg::fw_t        ws_fw,
        output logic                   ds_allowin,
        output logic                   ds_to_es_valid,
        output id_bus_pkg::ds_to_es_t  ds_to_es,
        output id_bus_pkg::br_t        br
);
        import la_isa_pkg::*;
        import id_bus_pkg::*;

        logic                      ds_valid;
        word_t                     ds_pc;
        word_t                     ds_inst;
        dec_t                      dec;
        word_t [num_rd_ports-1:0]  rf_rdata;
        word_t [num_rd_ports-1:0]  opnd;
        logic [num_rd_ports-1:0]   hazard;

        decode_latch u_latch (
                .clk            (clk),
                .reset          (reset),
                .fs_to_ds_valid (fs_to_ds_valid),
                .fs_to_ds       (fs_to_ds),
                .es_allowin     (es_allowin),
                .hazard         (hazard),
                .ds_allowin     (ds_allowin),
                .ds_valid       (ds_valid),
                .pc             (ds_pc),
                .inst           (ds_inst),
                .ds_to_es_valid (ds_to_es_valid)
        );

        inst_decode u_decode (
                .inst (ds_inst),
                .dec  (dec)
        );

        reg_file u_rf (
                .clk   (clk),
                .raddr (dec.raddr),
                .we    (wb_rf.we),
                .waddr (wb_rf.waddr),
                .wdata (wb_rf.wdata),
                .rdata (rf_rdata)
        );

        for (genvar g = 0; g < num_rd_ports; g++) begin : g_port
                operand_fwd u_fwd (
                        .raddr    (dec.raddr[g]),
                        .used     (dec.used[g]),
                        .rf_rdata (rf_rdata[g]),
                        .es_fw    (es_fw),
                        .ms_fw    (ms_fw),
                        .ws_fw    (ws_fw),
                        .value    (opnd[g]),
                        .hazard   (hazard[g])
                );
        end

        issue_unit u_issue (
                .ds_valid  (ds_valid),
                .pc        (ds_pc),
                .dec       (dec),
                .rj_value  (opnd[0]),
                .rkd_value (opnd[1]),
                .br        (br),
                .ds_to_es  (ds_to_es)
        );

endmodule

`default_nettype wire

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
        import la_isa_pkg::*;
        import id_bus_pkg::*;

        localparam int num_insts = 400;

        typedef struct packed {
                word_t       pc;
                inst_op_e    op;
                reg_addr_t   rd;
                reg_addr_t   rj;
                reg_addr_t   rk;
                logic [11:0] i12;
                logic [15:0] i16;
                logic [19:0] i20;
                logic [25:0] i26;
        } item_t;

        logic      clk;
        logic      reset;
        logic      fs_to_ds_valid;
        fs_to_ds_t fs_to_ds;
        logic      es_allowin;
        wb_rf_t    wb_rf;
        fw_t       es_fw;
        fw_t       ms_fw;
        fw_t       ws_fw;
        logic      ds_allowin;
        logic      ds_to_es_valid;
        ds_to_es_t ds_to_es;
        br_t       br;

        logic [31:0] lfsr = 32'h75533343;
        word_t       shadow [num_regs];
        item_t       f_item;  // offered by fetch
        item_t       m_item;  // held by the model
        logic        m_valid;
        int          issued;

        reg_addr_t m_r2;
        logic      used0;
        logic      used1;
        logic      haz0;
        logic      haz1;
        logic      m_hazard;
        logic      m_allowin;
        word_t     v0;
        word_t     v1;
        ds_to_es_t exp;
        logic      exp_taken;
        word_t     exp_target;

        inst_op_e ops [15] = '{inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_and,
                inst_or, inst_nor, inst_xor, inst_addi_w, inst_lu12i_w, inst_ld_w,
                inst_st_w, inst_beq, inst_bne, inst_b};

        id_stage u_dut (
                .clk            (clk),
                .reset          (reset),
                .fs_to_ds_valid (fs_to_ds_valid),
                .fs_to_ds       (fs_to_ds),
                .es_allowin     (es_allowin),
                .wb_rf          (wb_rf),
                .es_fw          (es_fw),
                .ms_fw          (ms_fw),
                .ws_fw          (ws_fw),
                .ds_allowin     (ds_allowin),
                .ds_to_es_valid (ds_to_es_valid),
                .ds_to_es       (ds_to_es),
                .br             (br)
        );

        always #2 clk = ~clk;

        // galois lfsr stepped once per bit
        function automatic logic [31:0] rand_bits(int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
                        r = {r[30:0], lfsr[0]};
                end
                return r;
        endfunction

        function automatic word_t encode(item_t it);
                case (it.op)
                        inst_add_w:   return {12'h001, 5'h00, it.rk, it.rj, it.rd};
                        inst_sub_w:   return {12'h001, 5'h02, it.rk, it.rj, it.rd};
                        inst_slt:     return {12'h001, 5'h04, it.rk, it.rj, it.rd};
                        inst_sltu:    return {12'h001, 5'h05, it.rk, it.rj, it.rd};
                        inst_nor:     return {12'h001, 5'h08, it.rk, it.rj, it.rd};
                        inst_and:     return {12'h001, 5'h09, it.rk, it.rj, it.rd};
                        inst_or:      return {12'h001, 5'h0a, it.rk, it.rj, it.rd};
                        inst_xor:     return {12'h001, 5'h0b, it.rk, it.rj, it.rd};
                        inst_addi_w:  return {10'h00a, it.i12, it.rj, it.rd};
                        inst_lu12i_w: return {7'h0a, it.i20, it.rd};
                        inst_ld_w:    return {10'h0a2, it.i12, it.rj, it.rd};
                        inst_st_w:    return {10'h0a6, it.i12, it.rj, it.rd};
                        inst_jirl:    return {6'h13, it.i16, it.rj, it.rd};
                        inst_b:       return {6'h14, it.i26[15:0], it.i26[25:16]};
                        inst_bl:      return {6'h15, it.i26[15:0], it.i26[25:16]};
                        inst_beq:     return {6'h16, it.i16, it.rj, it.rd};
                        default:      return {6'h17, it.i16, it.rj, it.rd};
                endcase
        endfunction

        function automatic word_t fwd_value(reg_addr_t a, fw_t es, fw_t ms, fw_t ws,
                                            word_t rf);
                if (a == '0) return '0;
                if (es.vwe && !es.is_load && es.dest == a) return es.wdata;
                if (ms.vwe && ms.dest == a) return ms.wdata;
                if (ws.vwe && ws.dest == a) return ws.wdata;
                return rf;
        endfunction

        task automatic fail_check(string name,
                                  logic [$bits(ds_to_es_t)-1:0] got,
                                  logic [$bits(ds_to_es_t)-1:0] want);
                $display("ERR %s got %h exp %h", name, got, want);
                $display("RESULT: FAIL");
                $fatal(1, "check failed");
        endtask

        // reference model of the held item
        always_comb begin
                m_r2  = (m_item.op inside {inst_st_w, inst_beq, inst_bne}) ? m_item.rd : m_item.rk;
                used0 = !(m_item.op inside {inst_lu12i_w, inst_b, inst_bl});
                used1 = m_item.op inside {inst_add_w, inst_sub_w, inst_slt, inst_sltu,
                        inst_and, inst_or, inst_nor, inst_xor, inst_st_w, inst_beq, inst_bne};
                v0 = fwd_value(m_item.rj, es_fw, ms_fw, ws_fw, shadow[m_item.rj]);
                v1 = fwd_value(m_r2, es_fw, ms_fw, ws_fw, shadow[m_r2]);
                haz0 = used0 && es_fw.vwe && es_fw.is_load && es_fw.dest != '0
                       && es_fw.dest == m_item.rj;
                haz1 = used1 && es_fw.vwe && es_fw.is_load && es_fw.dest != '0
                       && es_fw.dest == m_r2;
                m_hazard  = m_valid && (haz0 || haz1);
                m_allowin = !m_valid || (!m_hazard && es_allowin);

                exp.pc = m_item.pc;
                case (m_item.op)
                        inst_sub_w:   exp.alu_op = alu_sub;
                        inst_slt:     exp.alu_op = alu_slt;
                        inst_sltu:    exp.alu_op = alu_sltu;
                        inst_and:     exp.alu_op = alu_and;
                        inst_or:      exp.alu_op = alu_or;
                        inst_nor:     exp.alu_op = alu_nor;
                        inst_xor:     exp.alu_op = alu_xor;
                        inst_lu12i_w: exp.alu_op = alu_lui;
                        default:      exp.alu_op = alu_add;
                endcase
                exp.res_from_mem = m_item.op == inst_ld_w;
                exp.mem_we       = m_item.op == inst_st_w;
                exp.gr_we        = !(m_item.op inside {inst_st_w, inst_beq, inst_bne, inst_b});
                exp.dest         = (m_item.op == inst_bl) ? 5'd1 : m_item.rd;
                exp.alu_src1     = (m_item.op inside {inst_jirl, inst_bl}) ? m_item.pc : v0;
                if (m_item.op inside {inst_jirl, inst_bl})
                        exp.alu_src2 = 32'd4;
                else if (m_item.op == inst_lu12i_w)
                        exp.alu_src2 = {m_item.i20, 12'h000};
                else if (m_item.op inside {inst_addi_w, inst_ld_w, inst_st_w})
                        exp.alu_src2 = {{20{m_item.i12[11]}}, m_item.i12};
                else
                        exp.alu_src2 = v1;
                exp.rkd_value = v1;

                exp_taken = (m_item.op == inst_beq && v0 == v1)
                            || (m_item.op == inst_bne && v0 != v1)
                            || (m_item.op inside {inst_b, inst_bl, inst_jirl});
                if (m_item.op inside {inst_b, inst_bl})
                        exp_target = m_item.pc + {{4{m_item.i26[25]}}, m_item.i26, 2'b00};
                else
                        exp_target = (m_item.op == inst_jirl ? v0 : m_item.pc)
                                     + {{14{m_item.i16[15]}}, m_item.i16, 2'b00};
        end

        always @(posedge clk) begin
                if (reset) begin
                        m_valid <= 1'b0;
                        issued  <= 0;
                end else begin
                        if (m_allowin) begin
                                m_valid <= fs_to_ds_valid;
                                if (fs_to_ds_valid) m_item <= f_item;
                        end
                        if (m_valid && !m_hazard && es_allowin) issued <= issued + 1;
                end
                if (wb_rf.we && wb_rf.waddr != '0) shadow[wb_rf.waddr] <= wb_rf.wdata;
        end

        a_reset: assert property (@(posedge clk) $fell(reset) |->
                        !ds_to_es_valid && !br.taken && ds_allowin)
                else fail_check("reset_outputs", {ds_to_es_valid, br.taken, ds_allowin}, 3'b001);
        a_allowin: assert property (@(posedge clk) disable iff (reset)
                        ds_allowin == m_allowin)
                else fail_check("ds_allowin", ds_allowin, m_allowin);
        a_valid: assert property (@(posedge clk) disable iff (reset)
                        ds_to_es_valid == (m_valid && !m_hazard))
                else fail_check("ds_to_es_valid", ds_to_es_valid, m_valid && !m_hazard);
        a_bus: assert property (@(posedge clk) disable iff (reset)
                        m_valid && !m_hazard |-> ds_to_es == exp)
                else fail_check("ds_to_es", ds_to_es, exp);
        a_taken: assert property (@(posedge clk) disable iff (reset)
                        br.taken == (m_valid && exp_taken))
                else fail_check("br.taken", br.taken, m_valid && exp_taken);
        a_target: assert property (@(posedge clk) disable iff (reset)
                        br.taken |-> br.target == exp_target)
                else fail_check("br.target", br.target, exp_target);
        a_hold: assert property (@(posedge clk) disable iff (reset)
                        m_valid && !m_allowin |=> $stable({ds_to_es.pc, ds_to_es.alu_op,
                        ds_to_es.res_from_mem, ds_to_es.dest, ds_to_es.gr_we,
                        ds_to_es.mem_we}))
                else fail_check("ds_to_es", ds_to_es, $past(ds_to_es));

        task automatic drive_fw(output fw_t fw, input logic may_load);
                logic [1:0] pick;
                fw.vwe     = rand_bits(2) == 0;
                fw.is_load = may_load && rand_bits(2) == 0;
                pick       = rand_bits(2);
                fw.dest    = pick == 0 ? m_item.rj : pick == 1 ? m_r2 : rand_bits(5);
                fw.wdata   = rand_bits(32);
        endtask

        task automatic new_item(output item_t it);
                word_t w;
                it.pc  = rand_bits(30) << 2;
                it.op  = ops[rand_bits(4) % 15];
                if (rand_bits(3) == 0) it.op = rand_bits(1) ? inst_bl : inst_jirl;
                it.rj  = rand_bits(5);
                it.rd  = rand_bits(1) ? it.rj : rand_bits(5);  // equal operands for beq
                it.rk  = rand_bits(5);
                it.i12 = rand_bits(12);
                it.i16 = rand_bits(16);
                it.i20 = rand_bits(20);
                it.i26 = rand_bits(26);
                w      = encode(it);  // register fields as the decoder sees them
                it.rd  = w[4:0];
                it.rj  = w[9:5];
                it.rk  = w[14:10];
        endtask

        initial begin
                item_t it;
                fw_t   fw;
                clk            = 1'b0;
                reset          = 1'b1;
                fs_to_ds_valid = 1'b0;
                fs_to_ds       = '0;
                es_allowin     = 1'b1;
                wb_rf          = '0;
                es_fw          = '0;
                ms_fw          = '0;
                ws_fw          = '0;
                f_item         = '0;
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                for (int i = 1; i < num_regs; i++) begin  // fill the register file
                        wb_rf.we    <= 1'b1;
                        wb_rf.waddr <= reg_addr_t'(i);
                        wb_rf.wdata <= rand_bits(32);
                        @(posedge clk);
                end
                wb_rf.we <= 1'b0;
                while (issued < num_insts) begin
                        if (!fs_to_ds_valid || m_allowin) begin
                                new_item(it);
                                f_item         <= it;
                                fs_to_ds.pc    <= it.pc;
                                fs_to_ds.inst  <= encode(it);
                                fs_to_ds_valid <= rand_bits(2) != 0;
                        end
                        es_allowin  <= rand_bits(2) != 0;
                        wb_rf.we    <= rand_bits(1);
                        wb_rf.waddr <= rand_bits(5);
                        wb_rf.wdata <= rand_bits(32);
                        drive_fw(fw, 1'b1);
                        es_fw <= fw;
                        drive_fw(fw, 1'b0);
                        ms_fw <= fw;
                        drive_fw(fw, 1'b0);
                        ws_fw <= fw;
                        @(posedge clk);
                end
                repeat (2) @(posedge clk);
                $display("RESULT: PASS");
                $finish;
        end

        initial begin
                #((num_insts * 20 + 100) * 4);
                $display("timeout: the run hung before all instructions issued");
                $display("RESULT: FAIL");
                $fatal(1, "watchdog expired");
        end

endmodule

`default_nettype wire

// File: tb.f
verilog/la_isa_pkg.sv
verilog/id_bus_pkg.sv
verilog/decode_latch.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/operand_fwd.sv
verilog/issue_unit.sv
verilog/id_stage.sv
testbench/tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_id_stage \
        --Mdir obj_dir \
        -o sim_tb_id_stage \
        -f tb.f
status=$?
if [ $status -ne 0 ]; then
        echo "compile failed with status $status"
        exit $status
fi

./obj_dir/sim_tb_id_stage
status=$?
if [ $status -ne 0 ]; then
        echo "simulation failed with status $status"
        exit $status
fi

echo "simulation finished"
exit 0
